// File: stream_defs.svh
`ifndef STREAM_DEFS_SVH
`define STREAM_DEFS_SVH

// Packet geometry in 32-bit words
`define PACKET_WORDS    8
`define HDR_WORDS       4

// FIFO address widths
`define SAMPLE_FIFO_AW  4
`define FRAME_FIFO_AW   3

// GMII framing
`define PREAMBLE_BYTES  7
`define PREAMBLE_BYTE   8'h55
`define SFD_BYTE        8'hD5

// Minimum idle cycles between frames
`define IFG_BYTES       12

// Local experimental ethertype
`define ETHERTYPE       16'h88B5

`endif

// File: sample_pkg.sv
`default_nettype none

`include "stream_defs.svh"

package sample_pkg;

	// One ADC sample, two 16-bit channels side by side
	typedef logic [31:0] sample_t;

	// Sample with its write strobe, no back-pressure
	typedef struct packed {
		logic    we;
		sample_t data;
	} sample_in_t;

	// Fill level of the sample FIFO, one bit wider than the address
	typedef logic [`SAMPLE_FIFO_AW:0] sample_level_t;

endpackage

`default_nettype wire

// File: eth_pkg.sv
`default_nettype none

package eth_pkg;

	// MAC addresses for the frame header
	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
	} eth_cfg_t;

	// Word in the frame FIFO with its frame markers
	typedef struct packed {
		logic        sof;
		logic        eof;
		logic [31:0] data;
	} frame_word_t;

	// Registered GMII transmit pins
	typedef struct packed {
		logic [7:0] txd;
		logic       tx_en;
	} gmii_tx_t;

	typedef enum logic [1:0] {
		PB_IDLE,
		PB_HEADER,
		PB_PAYLOAD
	} pb_state_t;

	typedef enum logic [1:0] {
		TX_GAP,
		TX_PRE,
		TX_SFD,
		TX_DATA
	} tx_phase_t;

endpackage

`default_nettype wire

// File: word_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module word_fifo #(
	parameter type payload_t = logic [31:0],
	parameter int  AW        = 4
) (
	input  wire              GMII_GTX_CLK_int,
	input  wire              wb_rst,
	input  wire              clear_i,
	input  wire              wr_en_i,
	input  wire payload_t    wr_data_i,
	input  wire              rd_en_i,
	output payload_t         rd_data_o,
	output logic             empty_o,
	output logic             full_o,
	output logic [AW:0]      level_o,
	output logic             overflow_o
);

	localparam int DEPTH = 1 << AW;

	payload_t    mem [DEPTH];
	logic [AW:0] wr_ptr; // Extra MSB tells full from empty
	logic [AW:0] rd_ptr;
	logic        do_wr;
	logic        do_rd;

	assign level_o = wr_ptr - rd_ptr;
	assign empty_o = (wr_ptr == rd_ptr);
	assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
	                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_wr = wr_en_i & ~full_o & ~clear_i;
	assign do_rd = rd_en_i & ~empty_o & ~clear_i;

	// Write dropped on a full buffer
	assign overflow_o = wr_en_i & full_o & ~clear_i;

	// Head word always visible
	assign rd_data_o = mem[rd_ptr[AW-1:0]];

	//////////////////////////////
	// Pointers

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else if (clear_i) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	//////////////////////////////
	// Storage

	always_ff @(posedge GMII_GTX_CLK_int) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= wr_data_i;
	end

endmodule

`default_nettype wire

// File: stream_control.sv
`default_nettype none
`timescale 1ns/1ps

module stream_control (
	input  wire  GMII_GTX_CLK_int,
	input  wire  wb_rst,
	input  wire  sw_rx_enable_i,
	input  wire  sw_tx_enable_i,
	input  wire  overflow_pulse_i,
	output logic rx_clear_o,
	output logic tx_clear_o,
	output logic overflow_o
);

	logic [1:0] sw_meta; // {tx, rx}
	logic [1:0] sw_sync;

	//////////////////////////////
	// Switch synchronisers

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= {sw_tx_enable_i, sw_rx_enable_i};
			sw_sync <= sw_meta;
		end
	end

	// Each half of the datapath held cleared while its switch is off
	assign rx_clear_o = ~sw_sync[0]; // Sample FIFO
	assign tx_clear_o = ~sw_sync[1]; // Frame FIFO, builder and transmitter

	//////////////////////////////
	// Sticky overflow

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst)
			overflow_o <= 1'b0;
		else if (overflow_pulse_i)
			overflow_o <= 1'b1;
	end

endmodule

`default_nettype wire

// File: packet_builder.sv
`default_nettype none
`timescale 1ns/1ps

`include "stream_defs.svh"

module packet_builder (
	input  wire                            GMII_GTX_CLK_int,
	input  wire                            wb_rst,
	input  wire                            clear_i,
	input  wire eth_pkg::eth_cfg_t         cfg_i,
	input  wire sample_pkg::sample_level_t level_i,
	input  wire sample_pkg::sample_t       sample_i,
	output logic                           sample_rd_o,
	output eth_pkg::frame_word_t           word_o,
	output logic                           src_rdy_o,
	input  wire                            dst_rdy_i
);

	import eth_pkg::*;

	localparam int HCW = $clog2(`HDR_WORDS);
	localparam int PCW = $clog2(`PACKET_WORDS);

	pb_state_t      state;
	logic [HCW-1:0] hdr_cnt;
	logic [PCW-1:0] pay_cnt;
	logic [15:0]    seq_num;  // Wraps, restarts on clear
	logic [31:0]    hdr_word;
	logic           xfer;

	assign src_rdy_o   = (state != PB_IDLE);
	assign xfer        = src_rdy_o & dst_rdy_i;
	assign sample_rd_o = xfer & (state == PB_PAYLOAD);

	// Header words, MAC addresses packed big endian
	always_comb begin
		case (hdr_cnt)
			2'd0:    hdr_word = cfg_i.dst_mac[47:16];
			2'd1:    hdr_word = {cfg_i.dst_mac[15:0], cfg_i.src_mac[47:32]};
			2'd2:    hdr_word = cfg_i.src_mac[31:0];
			default: hdr_word = {`ETHERTYPE, seq_num};
		endcase
	end

	// Word on offer, held steady under back-pressure
	always_comb begin
		word_o.sof  = (state == PB_HEADER) && (hdr_cnt == '0);
		word_o.eof  = (state == PB_PAYLOAD) && (pay_cnt == PCW'(`PACKET_WORDS - 1));
		word_o.data = (state == PB_PAYLOAD) ? sample_i : hdr_word;
	end

	//////////////////////////////
	// Frame FSM

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			state   <= PB_IDLE;
			hdr_cnt <= '0;
			pay_cnt <= '0;
			seq_num <= '0;
		end else if (clear_i) begin
			state   <= PB_IDLE;
			hdr_cnt <= '0;
			pay_cnt <= '0;
			seq_num <= '0;
		end else begin
			case (state)
				PB_IDLE: begin
					// Full packet waiting in the sample FIFO
					if (level_i >= `PACKET_WORDS) begin
						state   <= PB_HEADER;
						hdr_cnt <= '0;
					end
				end
				PB_HEADER: begin
					if (xfer) begin
						if (hdr_cnt == HCW'(`HDR_WORDS - 1)) begin
							state   <= PB_PAYLOAD;
							pay_cnt <= '0;
						end else
							hdr_cnt <= hdr_cnt + 1'b1;
					end
				end
				PB_PAYLOAD: begin
					if (xfer) begin
						if (pay_cnt == PCW'(`PACKET_WORDS - 1)) begin
							state   <= PB_IDLE;
							seq_num <= seq_num + 1'b1;
						end else
							pay_cnt <= pay_cnt + 1'b1;
					end
				end
				default: state <= PB_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: gmii_tx.sv
`default_nettype none
`timescale 1ns/1ps

`include "stream_defs.svh"

module gmii_tx (
	input  wire                       GMII_GTX_CLK_int,
	input  wire                       wb_rst,
	input  wire                       clear_i,
	input  wire eth_pkg::frame_word_t word_i,
	input  wire                       empty_i,
	output logic                      rd_en_o,
	output eth_pkg::gmii_tx_t         gmii_o
);

	import eth_pkg::*;

	localparam int CW = $clog2(`IFG_BYTES + 1);

	tx_phase_t phase;
	tx_phase_t phase_nxt;
	logic [CW-1:0] cnt;      // Gap, preamble or byte-in-word count
	logic [CW-1:0] cnt_nxt;
	gmii_tx_t byte_sel;      // Byte chosen this cycle, on the pins next cycle

	//////////////////////////////
	// Byte selection

	always_comb begin
		phase_nxt = phase;
		cnt_nxt   = cnt;
		rd_en_o   = 1'b0;
		byte_sel  = '0;
		case (phase)
			TX_GAP: begin
				if (cnt != CW'(`IFG_BYTES - 1))
					cnt_nxt = cnt + 1'b1;
				else if (!empty_i && word_i.sof) begin
					phase_nxt = TX_PRE;
					cnt_nxt   = '0;
				end else if (!empty_i)
					rd_en_o = 1'b1; // Drop a stray word outside a frame
			end
			TX_PRE: begin
				byte_sel = '{txd: `PREAMBLE_BYTE, tx_en: 1'b1};
				if (cnt == CW'(`PREAMBLE_BYTES - 1)) begin
					phase_nxt = TX_SFD;
					cnt_nxt   = '0;
				end else
					cnt_nxt = cnt + 1'b1;
			end
			TX_SFD: begin
				byte_sel  = '{txd: `SFD_BYTE, tx_en: 1'b1};
				phase_nxt = TX_DATA;
				cnt_nxt   = '0;
			end
			TX_DATA: begin
				// MSB first
				byte_sel.txd   = word_i.data[31 - 8*cnt[1:0] -: 8];
				byte_sel.tx_en = 1'b1;
				if (cnt[1:0] == 2'd3) begin
					rd_en_o = !empty_i; // Word done, pop it
					cnt_nxt = '0;
					if (word_i.eof)
						phase_nxt = TX_GAP;
				end else
					cnt_nxt = cnt + 1'b1;
			end
			default: phase_nxt = TX_GAP;
		endcase
	end

	//////////////////////////////
	// State and output registers

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			phase  <= TX_GAP;
			cnt    <= '0;
			gmii_o <= '0;
		end else if (clear_i) begin
			phase  <= TX_GAP;
			cnt    <= '0;
			gmii_o <= '0;
		end else begin
			phase  <= phase_nxt;
			cnt    <= cnt_nxt;
			gmii_o <= byte_sel;
		end
	end

endmodule

`default_nettype wire

// File: stream_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "stream_defs.svh"

module stream_top (
	input  wire                         GMII_GTX_CLK_int,
	input  wire                         wb_rst,
	input  wire sample_pkg::sample_in_t sample_i,
	input  wire eth_pkg::eth_cfg_t      cfg_i,
	input  wire                         sw_rx_enable_i,
	input  wire                         sw_tx_enable_i,
	output eth_pkg::gmii_tx_t           gmii_o,
	output logic                        overflow_o
);

	import sample_pkg::*;
	import eth_pkg::*;

	logic          rx_clear;
	logic          tx_clear;
	logic          sample_ovf;   // Pulse, sample lost
	sample_level_t sample_level;
	sample_t       sample_head;
	logic          sample_rd;
	frame_word_t   pb_word;
	logic          pb_src_rdy;
	logic          frame_full;
	frame_word_t   tx_word;
	logic          tx_empty;
	logic          tx_rd;

	// Frame FIFO ready while not full
	wire pb_dst_rdy = ~frame_full;

	stream_control u_stream_control (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.sw_rx_enable_i   (sw_rx_enable_i),
		.sw_tx_enable_i   (sw_tx_enable_i),
		.overflow_pulse_i (sample_ovf),
		.rx_clear_o       (rx_clear),
		.tx_clear_o       (tx_clear),
		.overflow_o       (overflow_o)
	);

	//////////////////////////////
	// Sample side

	word_fifo #(.payload_t(sample_t), .AW(`SAMPLE_FIFO_AW)) u_sample_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.clear_i          (rx_clear),
		.wr_en_i          (sample_i.we),
		.wr_data_i        (sample_i.data),
		.rd_en_i          (sample_rd),
		.rd_data_o        (sample_head),
		.empty_o          (),
		.full_o           (),
		.level_o          (sample_level),
		.overflow_o       (sample_ovf)
	);

	packet_builder u_packet_builder (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.clear_i          (tx_clear),
		.cfg_i            (cfg_i),
		.level_i          (sample_level),
		.sample_i         (sample_head),
		.sample_rd_o      (sample_rd),
		.word_o           (pb_word),
		.src_rdy_o        (pb_src_rdy),
		.dst_rdy_i        (pb_dst_rdy)
	);

	//////////////////////////////
	// Frame side

	word_fifo #(.payload_t(frame_word_t), .AW(`FRAME_FIFO_AW)) u_frame_fifo (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.clear_i          (tx_clear),
		.wr_en_i          (pb_src_rdy),
		.wr_data_i        (pb_word),
		.rd_en_i          (tx_rd),
		.rd_data_o        (tx_word),
		.empty_o          (tx_empty),
		.full_o           (frame_full),
		.level_o          (),
		.overflow_o       ()
	);

	gmii_tx u_gmii_tx (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.clear_i          (tx_clear),
		.word_i           (tx_word),
		.empty_i          (tx_empty),
		.rd_en_o          (tx_rd),
		.gmii_o           (gmii_o)
	);

endmodule

`default_nettype wire

// File: stream_checker.sv
`default_nettype none
`timescale 1ns/1ps

`include "stream_defs.svh"

module stream_checker (
	input wire                    GMII_GTX_CLK_int,
	input wire                    wb_rst,
	input wire eth_pkg::gmii_tx_t gmii_i
);

	import eth_pkg::*;

	localparam int FRAME_LEN = `PREAMBLE_BYTES + 1 + 4 * (`HDR_WORDS + `PACKET_WORDS);

	logic [7:0] hi_cnt;     // Length of the current TX_EN run
	logic [7:0] lo_cnt;     // Idle cycles since the last frame, saturating
	logic       seen_frame;

	always_ff @(posedge GMII_GTX_CLK_int or posedge wb_rst) begin
		if (wb_rst) begin
			hi_cnt     <= '0;
			lo_cnt     <= '0;
			seen_frame <= 1'b0;
		end else if (gmii_i.tx_en) begin
			hi_cnt     <= hi_cnt + 1'b1;
			lo_cnt     <= '0;
			seen_frame <= 1'b1;
		end else begin
			hi_cnt <= '0;
			if (lo_cnt != 8'hff)
				lo_cnt <= lo_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// Frame protocol

	frame_len_a: assert property (@(posedge GMII_GTX_CLK_int) disable iff (wb_rst)
		$fell(gmii_i.tx_en) |-> (hi_cnt == FRAME_LEN))
		else $error("TX_EN frame lasted %0d cycles", hi_cnt);

	ifg_len_a: assert property (@(posedge GMII_GTX_CLK_int) disable iff (wb_rst)
		$rose(gmii_i.tx_en) |-> (lo_cnt >= `IFG_BYTES))
		else $error("Interframe gap of only %0d cycles", lo_cnt);

	// Very first frame opens with preamble
	first_byte_a: assert property (@(posedge GMII_GTX_CLK_int) disable iff (wb_rst)
		($rose(gmii_i.tx_en) && !seen_frame) |-> (gmii_i.txd == `PREAMBLE_BYTE))
		else $error("First TX_EN byte was 0x%02h", gmii_i.txd);

endmodule

bind stream_top stream_checker u_stream_checker (
	.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
	.wb_rst           (wb_rst),
	.gmii_i           (gmii_o)
);

`default_nettype wire

// File: tb_stream_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "stream_defs.svh"

module tb_stream_top;

	import sample_pkg::*;
	import eth_pkg::*;

	localparam int FRAME_LEN     = `PREAMBLE_BYTES + 1 + 4 * (`HDR_WORDS + `PACKET_WORDS);
	localparam int SAMPLE_DEPTH  = 1 << `SAMPLE_FIFO_AW;
	localparam int NUM_ROWS      = 10;
	localparam int FRAME_TIMEOUT = 2000; // Cycles allowed per awaited frame set
	localparam int QUIET_CYCLES  = 120;  // Longer than one frame plus gap

	typedef struct packed {
		logic       rx_en;
		logic       tx_en;
		logic [7:0] n_samples;
		logic [7:0] pace;      // Cycles per written sample
		logic [7:0] frames;    // New frames expected in this row
		logic       ovf;
	} row_t;

	logic        GMII_GTX_CLK_int;
	logic        wb_rst;
	sample_in_t  sample;
	eth_cfg_t    cfg;
	logic        sw_rx_enable;
	logic        sw_tx_enable;
	gmii_tx_t    gmii;
	logic        overflow;

	row_t        rows [NUM_ROWS];
	sample_t     model_q [$];   // Sample FIFO contents
	logic [7:0]  exp_bytes [$]; // Bytes still due on GMII
	logic [15:0] seq_model;
	logic        rx_on;
	logic        tx_on;
	integer      seed;
	int          errors;
	int          checks;
	int          frames_seen;
	logic        in_frame;
	int          frame_len;
	int          gap_len;

	stream_top u_dut (
		.GMII_GTX_CLK_int (GMII_GTX_CLK_int),
		.wb_rst           (wb_rst),
		.sample_i         (sample),
		.cfg_i            (cfg),
		.sw_rx_enable_i   (sw_rx_enable),
		.sw_tx_enable_i   (sw_tx_enable),
		.gmii_o           (gmii),
		.overflow_o       (overflow)
	);

	always #50 GMII_GTX_CLK_int = ~GMII_GTX_CLK_int;

	//////////////////////////////
	// Helpers

	task automatic step();
		@(posedge GMII_GTX_CLK_int);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
	                           input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
			errors++;
		end
	endtask

	function automatic void push_word(input logic [31:0] w);
		int i;
		for (i = 3; i >= 0; i--)
			exp_bytes.push_back(w[8*i +: 8]); // MSB first
	endfunction

	function automatic void push_mac(input logic [47:0] mac);
		int i;
		for (i = 5; i >= 0; i--)
			exp_bytes.push_back(mac[8*i +: 8]);
	endfunction

	// Every full packet in the model becomes one expected frame while tx runs
	function automatic void predict_frames();
		int i;
		while (tx_on && model_q.size() >= `PACKET_WORDS) begin
			for (i = 0; i < `PREAMBLE_BYTES; i++)
				exp_bytes.push_back(`PREAMBLE_BYTE);
			exp_bytes.push_back(`SFD_BYTE);
			push_mac(cfg.dst_mac);
			push_mac(cfg.src_mac);
			push_word({`ETHERTYPE, seq_model});
			for (i = 0; i < `PACKET_WORDS; i++)
				push_word(model_q.pop_front());
			seq_model++;
		end
	endfunction

	function automatic void model_write(input sample_t s);
		if (rx_on && model_q.size() < SAMPLE_DEPTH) // Full FIFO drops the sample
			model_q.push_back(s);
		predict_frames();
	endfunction

	task automatic apply_switches(input logic rx, input logic tx);
		if (!tx)
			seq_model = '0; // Numbering restarts on tx clear
		if (!rx)
			model_q.delete();
		rx_on        = rx;
		tx_on        = tx;
		sw_rx_enable = rx;
		sw_tx_enable = tx;
		repeat (4) step(); // Two-flop sync plus margin
		predict_frames();
	endtask

	task automatic write_samples(input int n, input int pace);
		int      k;
		sample_t s;
		for (k = 0; k < n; k++) begin
			s           = $random(seed);
			sample.we   = 1'b1;
			sample.data = s;
			model_write(s);
			step();
			sample.we = 1'b0;
			repeat (pace - 1) step();
		end
	endtask

	task automatic wait_frames(input int target);
		int n;
		n = 0;
		while (frames_seen < target && n < FRAME_TIMEOUT) begin
			step();
			n++;
		end
		checks++;
		assert (frames_seen >= target) else begin
			$display("ERROR: timed out after %0d cycles waiting for frame %0d", n, target);
			errors++;
		end
	endtask

	task automatic run_row(input int idx, input row_t r);
		int start;
		start = frames_seen;
		apply_switches(r.rx_en, r.tx_en);
		write_samples(r.n_samples, r.pace);
		wait_frames(start + r.frames);
		repeat (QUIET_CYCLES) step(); // No extra frame may follow
		check_value($sformatf("row %0d frame count", idx), 32'(frames_seen - start),
		            32'(r.frames));
		check_value($sformatf("row %0d overflow_o", idx), 32'(overflow), 32'(r.ovf));
	endtask

	//////////////////////////////
	// GMII monitor

	always @(negedge GMII_GTX_CLK_int) begin
		if (wb_rst) begin
			in_frame = 1'b0;
			gap_len  = 0;
		end else if (gmii.tx_en) begin
			if (!in_frame) begin
				if (frames_seen > 0) begin
					checks++;
					assert (gap_len >= `IFG_BYTES) else begin
						$display("ERROR: interframe gap of %0d cycles is too short", gap_len);
						errors++;
					end
				end
				in_frame  = 1'b1;
				frame_len = 0;
			end
			frame_len++;
			checks++;
			assert (exp_bytes.size() != 0) else begin
				$display("ERROR: GMII byte 0x%02h sent while no frame was expected", gmii.txd);
				errors++;
			end
			if (exp_bytes.size() != 0)
				check_value("gmii_o.txd", 32'(gmii.txd), 32'(exp_bytes.pop_front()));
		end else begin
			if (in_frame) begin
				check_value("frame length", 32'(frame_len), 32'(FRAME_LEN));
				frames_seen++;
				in_frame = 1'b0;
				gap_len  = 0;
			end
			if (gap_len < 1000)
				gap_len++;
		end
	end

	//////////////////////////////
	// Stimulus table

	initial begin
		int i;
		// rx_en, tx_en, samples, pace, new frames, overflow
		rows[0] = '{1'b1, 1'b1, 8'd8,  8'd1,  8'd1, 1'b0}; // One full packet
		rows[1] = '{1'b1, 1'b1, 8'd5,  8'd1,  8'd0, 1'b0}; // Short packet waits
		rows[2] = '{1'b1, 1'b1, 8'd3,  8'd1,  8'd1, 1'b0}; // Completed
		rows[3] = '{1'b1, 1'b0, 8'd0,  8'd1,  8'd0, 1'b0}; // Sequence restart
		rows[4] = '{1'b1, 1'b1, 8'd24, 8'd10, 8'd3, 1'b0}; // Three in a row
		rows[5] = '{1'b0, 1'b1, 8'd10, 8'd1,  8'd0, 1'b0}; // Samples discarded
		rows[6] = '{1'b1, 1'b1, 8'd0,  8'd1,  8'd0, 1'b0};
		rows[7] = '{1'b1, 1'b0, 8'd20, 8'd1,  8'd0, 1'b1}; // Overflow while tx off
		rows[8] = '{1'b1, 1'b1, 8'd0,  8'd1,  8'd2, 1'b1}; // First 16 samples only
		rows[9] = '{1'b1, 1'b1, 8'd8,  8'd1,  8'd1, 1'b1};

		seed             = 32'hfe6a_fbb0;
		errors           = 0;
		checks           = 0;
		frames_seen      = 0;
		in_frame         = 1'b0;
		frame_len        = 0;
		gap_len          = 0;
		seq_model        = '0;
		rx_on            = 1'b0;
		tx_on            = 1'b0;
		GMII_GTX_CLK_int = 1'b0;
		wb_rst           = 1'b1;
		sample           = '0;
		cfg              = '{dst_mac: 48'h02_00_5e_10_20_30, src_mac: 48'h02_0a_35_00_00_01};
		sw_rx_enable     = 1'b0;
		sw_tx_enable     = 1'b0;

		repeat (10) @(posedge GMII_GTX_CLK_int);
		#1;
		wb_rst = 1'b0;

		for (i = 0; i < NUM_ROWS; i++)
			run_row(i, rows[i]);
		check_value("pending GMII bytes", 32'(exp_bytes.size()), 32'd0);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
sample_pkg.sv
eth_pkg.sv
word_fifo.sv
stream_control.sv
packet_builder.sv
gmii_tx.sv
stream_top.sv
stream_checker.sv
tb_stream_top.sv

// File: Makefile
VERILATOR = verilator
TOP       = tb_stream_top
FILELIST  = sources.f
VFLAGS    = --binary --timing --assert -Wno-fatal
LINTFLAGS = --lint-only --timing -Wall
OBJDIR    = obj_dir
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST)) stream_defs.svh

.PHONY: all run lint clean

all: run

$(OBJDIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "Simulation FAILED"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
